//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        op_invalid,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_slt,
        op_addi,
        op_lu12i,
        op_ld,
        op_st,
        op_beq,
        op_bne,
        op_b
    } op_e;

    // Register and immediate fields.
    localparam int rd_lo      = 0;
    localparam int rd_hi      = 4;
    localparam int rj_lo      = 5;
    localparam int rj_hi      = 9;
    localparam int rk_lo      = 10;
    localparam int rk_hi      = 14;
    localparam int si12_lo    = 10;
    localparam int si12_hi    = 21;
    localparam int si20_lo    = 5;
    localparam int si20_hi    = 24;
    localparam int offs16_lo  = 10;
    localparam int offs16_hi  = 25;
    // Upper offset bits of b sit in the low field.
    localparam int offs26h_lo = 0;
    localparam int offs26h_hi = 9;

    // Major opcode fields, each running up to bit 31.
    localparam int op17_lo = 15;
    localparam int op10_lo = 22;
    localparam int op7_lo  = 25;
    localparam int op6_lo  = 26;

    localparam logic [16:0] opc_add_w  = 17'h00020;
    localparam logic [16:0] opc_sub_w  = 17'h00022;
    localparam logic [16:0] opc_slt    = 17'h00024;
    localparam logic [16:0] opc_and    = 17'h00029;
    localparam logic [16:0] opc_or     = 17'h0002a;
    localparam logic [9:0]  opc_addi_w = 10'h00a;
    localparam logic [9:0]  opc_ld_w   = 10'h0a2;
    localparam logic [9:0]  opc_st_w   = 10'h0a6;
    localparam logic [6:0]  opc_lu12i  = 7'h0a;
    localparam logic [5:0]  opc_beq    = 6'h16;
    localparam logic [5:0]  opc_bne    = 6'h17;
    localparam logic [5:0]  opc_b      = 6'h14;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // PC and instruction.
    localparam int to_id_w  = 32 + 32;
    // PC, opcode, operands, immediate, destination, write enable.
    localparam int to_ex_w  = 32 + 4 + 32 + 32 + 32 + 5 + 1;
    // PC, write enable, is-load, destination, result.
    localparam int to_mem_w = 32 + 1 + 1 + 5 + 32;
    localparam int to_wb_w  = 32 + 1 + 5 + 32;
    // Taken flag and target.
    localparam int br_w     = 1 + 32;
    // Valid, write enable, is-load, destination, value.
    localparam int fwd_w    = 1 + 1 + 1 + 5 + 32;

endpackage

`default_nettype wire

//--- rtl/regfile.sv
`default_nettype none

module regfile import isa_pkg::*; #(
    parameter int RF_DEPTH_LOG2 = 5
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    output word_t         rdata1,
    output word_t         rdata2,
    input  wire           we,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata
);

    word_t regs [2**RF_DEPTH_LOG2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**RF_DEPTH_LOG2; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- rtl/if_stage.sv
`default_nettype none

module if_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    output logic              inst_sram_en,
    output word_t             inst_sram_addr,
    input  wire word_t        inst_sram_rdata,
    input  wire               to_if_valid,
    input  wire               id_allow_in,
    output logic              if_to_id_valid,
    output logic [to_id_w-1:0] to_id_data,
    input  wire [br_w-1:0]    br_data
);

    logic  if_valid;
    logic  if_allow_in;
    word_t pc;
    word_t next_pc;
    logic  br_taken;
    word_t br_target;
    logic  hold_valid;
    word_t inst_hold;
    word_t inst;

    assign {br_taken, br_target} = br_data;

    assign next_pc        = br_taken ? br_target : pc + 32'd4;
    assign if_allow_in    = !if_valid || id_allow_in;
    assign inst_sram_en   = to_if_valid && if_allow_in;
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
            pc       <= reset_pc - 32'd4;
        end else if (if_allow_in) begin
            if_valid <= to_if_valid;
            if (to_if_valid) begin
                pc <= next_pc;
            end
        end
    end

    // Keep the returned word while decode is stalled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (inst_sram_en) begin
            hold_valid <= 1'b0;
        end else if (if_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && !hold_valid && !inst_sram_en) begin
            inst_hold <= inst_sram_rdata;
        end
    end

    assign inst = hold_valid ? inst_hold : inst_sram_rdata;

    // Wrong-path word is dropped when decode takes a branch.
    assign if_to_id_valid = if_valid && !br_taken;
    assign to_id_data     = {pc, inst};

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
`default_nettype none

module id_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int RF_DEPTH_LOG2 = 5
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire [to_id_w-1:0]  to_id_data,
    input  wire                if_to_id_valid,
    output logic               id_allow_in,
    output logic [to_ex_w-1:0] to_ex_data,
    output logic               id_to_ex_valid,
    input  wire                ex_allow_in,
    output logic [br_w-1:0]    br_data,
    output reg_idx_t           rf_raddr1,
    output reg_idx_t           rf_raddr2,
    input  wire word_t         rf_rdata1,
    input  wire word_t         rf_rdata2,
    input  wire [fwd_w-1:0]    ex_forward,
    input  wire [fwd_w-1:0]    mem_forward,
    input  wire [fwd_w-1:0]    wb_forward
);

    logic                     id_valid;
    logic                     id_ready_go;
    logic [to_id_w-1:0]       id_data;
    word_t                    pc;
    word_t                    inst;
    op_e                      op;
    logic [RF_DEPTH_LOG2-1:0] src1;
    logic [RF_DEPTH_LOG2-1:0] src2;
    reg_idx_t                 dest;
    logic                     use1;
    logic                     use2;
    logic                     gr_we;
    word_t                    imm;
    word_t                    opnd1;
    word_t                    opnd2;
    logic                     load_use;
    logic                     br_taken;

    // Live record writing a nonzero register that matches addr.
    function automatic logic fwd_hit(input logic [fwd_w-1:0] rec, input reg_idx_t addr);
        fwd_hit = rec[39] && rec[38] && rec[36:32] == addr && addr != '0;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (id_allow_in) begin
            id_valid <= if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allow_in) begin
            id_data <= to_id_data;
        end
    end

    assign {pc, inst} = id_data;

    //////////////////////////////////////////////////////////////////////
    // Decode.

    always_comb begin
        op = op_invalid;
        if (inst[31:op17_lo] == opc_add_w)       op = op_add;
        else if (inst[31:op17_lo] == opc_sub_w)  op = op_sub;
        else if (inst[31:op17_lo] == opc_slt)    op = op_slt;
        else if (inst[31:op17_lo] == opc_and)    op = op_and;
        else if (inst[31:op17_lo] == opc_or)     op = op_or;
        else if (inst[31:op10_lo] == opc_addi_w) op = op_addi;
        else if (inst[31:op10_lo] == opc_ld_w)   op = op_ld;
        else if (inst[31:op10_lo] == opc_st_w)   op = op_st;
        else if (inst[31:op7_lo] == opc_lu12i)   op = op_lu12i;
        else if (inst[31:op6_lo] == opc_beq)     op = op_beq;
        else if (inst[31:op6_lo] == opc_bne)     op = op_bne;
        else if (inst[31:op6_lo] == opc_b)       op = op_b;
    end

    always_comb begin
        use1  = 1'b1;
        use2  = 1'b0;
        gr_we = 1'b1;
        src2  = inst[rk_hi:rk_lo];
        case (op)
            op_add, op_sub, op_and, op_or, op_slt: use2 = 1'b1;
            op_lu12i: use1 = 1'b0;
            op_st, op_beq, op_bne: begin
                // Second source comes from the rd field.
                use2  = 1'b1;
                gr_we = 1'b0;
                src2  = inst[rd_hi:rd_lo];
            end
            op_b, op_invalid: begin
                use1  = 1'b0;
                gr_we = 1'b0;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            op_lu12i: imm = {inst[si20_hi:si20_lo], 12'b0};
            op_beq, op_bne: imm = {{14{inst[offs16_hi]}}, inst[offs16_hi:offs16_lo], 2'b0};
            op_b: imm = {{4{inst[offs26h_hi]}}, inst[offs26h_hi:offs26h_lo],
                         inst[offs16_hi:offs16_lo], 2'b0};
            default: imm = {{20{inst[si12_hi]}}, inst[si12_hi:si12_lo]};
        endcase
    end

    assign src1      = inst[rj_hi:rj_lo];
    assign dest      = inst[rd_hi:rd_lo];
    assign rf_raddr1 = src1;
    assign rf_raddr2 = src2;

    //////////////////////////////////////////////////////////////////////
    // Operand forwarding, nearest stage wins.

    always_comb begin
        opnd1 = rf_rdata1;
        if (fwd_hit(wb_forward, src1))  opnd1 = wb_forward[31:0];
        if (fwd_hit(mem_forward, src1)) opnd1 = mem_forward[31:0];
        if (fwd_hit(ex_forward, src1))  opnd1 = ex_forward[31:0];
        opnd2 = rf_rdata2;
        if (fwd_hit(wb_forward, src2))  opnd2 = wb_forward[31:0];
        if (fwd_hit(mem_forward, src2)) opnd2 = mem_forward[31:0];
        if (fwd_hit(ex_forward, src2))  opnd2 = ex_forward[31:0];
    end

    // Load data is not ready until the load reaches memory.
    assign load_use = ex_forward[37] && ((use1 && fwd_hit(ex_forward, src1)) ||
                                         (use2 && fwd_hit(ex_forward, src2)));

    assign id_ready_go    = !load_use;
    assign id_allow_in    = !id_valid || (id_ready_go && ex_allow_in);
    assign id_to_ex_valid = id_valid && id_ready_go;

    assign br_taken = id_valid && id_ready_go && ex_allow_in &&
                      (op == op_b || (op == op_beq && opnd1 == opnd2) ||
                       (op == op_bne && opnd1 != opnd2));
    assign br_data  = {br_taken, pc + imm};

    assign to_ex_data = {pc, op, opnd1, opnd2, imm, dest, gr_we};

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
`default_nettype none

module ex_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [to_ex_w-1:0]   to_ex_data,
    input  wire                 id_to_ex_valid,
    output logic                ex_allow_in,
    output logic [to_mem_w-1:0] to_mem_data,
    output logic                ex_to_mem_valid,
    input  wire                 mem_allow_in,
    output logic                data_sram_en,
    output logic [3:0]          data_sram_we,
    output word_t               data_sram_addr,
    output word_t               data_sram_wdata,
    output logic [fwd_w-1:0]    ex_forward
);

    logic               ex_valid;
    logic [to_ex_w-1:0] ex_data;
    word_t              pc;
    logic [3:0]         op_bits;
    op_e                op;
    word_t              src1;
    word_t              src2;
    word_t              imm;
    reg_idx_t           dest;
    logic               gr_we;
    logic               is_load;
    logic               is_store;
    word_t              result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ex_allow_in) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allow_in) begin
            ex_data <= to_ex_data;
        end
    end

    assign {pc, op_bits, src1, src2, imm, dest, gr_we} = ex_data;
    assign op       = op_e'(op_bits);
    assign is_load  = op == op_ld;
    assign is_store = op == op_st;

    always_comb begin
        case (op)
            op_add:   result = src1 + src2;
            op_sub:   result = src1 - src2;
            op_and:   result = src1 & src2;
            op_or:    result = src1 | src2;
            op_slt:   result = {31'b0, $signed(src1) < $signed(src2)};
            op_lu12i: result = imm;
            // addi.w and the load/store address.
            default:  result = src1 + imm;
        endcase
    end

    assign ex_allow_in     = !ex_valid || mem_allow_in;
    assign ex_to_mem_valid = ex_valid;

    assign data_sram_en    = ex_valid && mem_allow_in && (is_load || is_store);
    assign data_sram_we    = {4{data_sram_en && is_store}};
    assign data_sram_addr  = result;
    assign data_sram_wdata = src2;

    assign to_mem_data = {pc, gr_we, is_load, dest, result};
    assign ex_forward  = {ex_valid, gr_we, is_load, dest, result};

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`default_nettype none

module mem_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire [to_mem_w-1:0] to_mem_data,
    input  wire                ex_to_mem_valid,
    output logic               mem_allow_in,
    input  wire word_t         data_sram_rdata,
    output logic [to_wb_w-1:0] to_wb_data,
    output logic               mem_to_wb_valid,
    input  wire                wb_allow_in,
    output logic [fwd_w-1:0]   mem_forward
);

    logic                mem_valid;
    logic [to_mem_w-1:0] mem_data;
    word_t               pc;
    logic                gr_we;
    logic                is_load;
    reg_idx_t            dest;
    word_t               alu_result;
    word_t               result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (mem_allow_in) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allow_in) begin
            mem_data <= to_mem_data;
        end
    end

    assign {pc, gr_we, is_load, dest, alu_result} = mem_data;

    // Read data returns while the load sits here.
    assign result = is_load ? data_sram_rdata : alu_result;

    assign mem_allow_in    = !mem_valid || wb_allow_in;
    assign mem_to_wb_valid = mem_valid;
    assign to_wb_data      = {pc, gr_we, dest, result};
    assign mem_forward     = {mem_valid, gr_we, is_load, dest, result};

endmodule

`default_nettype wire

//--- rtl/wb_stage.sv
`default_nettype none

module wb_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire [to_wb_w-1:0] to_wb_data,
    input  wire               mem_to_wb_valid,
    output logic              wb_allow_in,
    output logic              rf_we,
    output reg_idx_t          rf_waddr,
    output word_t             rf_wdata,
    output word_t             debug_wb_pc,
    output logic [3:0]        debug_wb_rf_we,
    output reg_idx_t          debug_wb_rf_wnum,
    output word_t             debug_wb_rf_wdata,
    output logic [fwd_w-1:0]  wb_forward
);

    logic               wb_valid;
    logic [to_wb_w-1:0] wb_data;
    word_t              pc;
    logic               gr_we;
    reg_idx_t           dest;
    word_t              result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid) begin
            wb_data <= to_wb_data;
        end
    end

    assign {pc, gr_we, dest, result} = wb_data;

    // Writeback always retires in one cycle.
    assign wb_allow_in = 1'b1;

    assign rf_we    = wb_valid && gr_we && dest != '0;
    assign rf_waddr = dest;
    assign rf_wdata = result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = result;

    assign wb_forward = {wb_valid, gr_we, 1'b0, dest, result};

endmodule

`default_nettype wire

//--- rtl/mycpu_top.sv
`default_nettype none

module mycpu_top import isa_pkg::*, pipe_pkg::*; #(
    parameter int RF_DEPTH_LOG2 = 5
) (
    input  wire        clk,
    input  wire        rst_n,
    // Instruction SRAM.
    output wire        inst_sram_en,
    output word_t      inst_sram_addr,
    input  wire word_t inst_sram_rdata,
    // Data SRAM.
    output wire        data_sram_en,
    output wire [3:0]  data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  wire word_t data_sram_rdata,
    // Writeback trace.
    output word_t      debug_wb_pc,
    output wire [3:0]  debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    wire id_allow_in;
    wire ex_allow_in;
    wire mem_allow_in;
    wire wb_allow_in;

    wire to_if_valid;
    wire if_to_id_valid;
    wire id_to_ex_valid;
    wire ex_to_mem_valid;
    wire mem_to_wb_valid;

    wire [to_id_w-1:0]  to_id_data;
    wire [to_ex_w-1:0]  to_ex_data;
    wire [to_mem_w-1:0] to_mem_data;
    wire [to_wb_w-1:0]  to_wb_data;
    wire [br_w-1:0]     br_data;

    wire [fwd_w-1:0] ex_forward;
    wire [fwd_w-1:0] mem_forward;
    wire [fwd_w-1:0] wb_forward;

    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    wire      rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // Fetch runs as soon as reset is released.
    assign to_if_valid = rst_n;

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages.

    if_stage u_if_stage (.*);

    id_stage #(
        .RF_DEPTH_LOG2 (RF_DEPTH_LOG2)
    ) u_id_stage (.*);

    ex_stage u_ex_stage (.*);

    mem_stage u_mem_stage (.*);

    wb_stage u_wb_stage (.*);

    regfile #(
        .RF_DEPTH_LOG2 (RF_DEPTH_LOG2)
    ) u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

//--- verif/tb_mycpu.sv
`default_nettype none

module tb_mycpu import isa_pkg::*; ();

    localparam int mem_words = 1024;

    logic       clk;
    logic       rst_n;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t      imem [mem_words];
    word_t      dmem [mem_words];

    string      exp_name [$];
    word_t      exp_pc [$];
    reg_idx_t   exp_wnum [$];
    word_t      exp_wdata [$];
    int         prog_words;
    int         cycle_limit;
    int         cycles;
    int         seen;
    int         drain;

    mycpu_top #(
        .RF_DEPTH_LOG2 (5)
    ) dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and trace compares.

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_pc(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s pc: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_we(input string name, input logic [3:0] expected,
                            input logic [3:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s we: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_wnum(input string name, input reg_idx_t expected,
                              input reg_idx_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s wnum: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_wdata(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s wdata: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_fields(input int got, input int want, input string kw);
        if (got != want) begin
            $display("Malformed %s line in the case file", kw);
            abort_run();
        end
    endtask

    // Reads program words and the expected trace.
    task automatic load_cases();
        int               fd;
        int               code;
        string            kw;
        string            name;
        word_t            addr;
        word_t            value;
        reg_idx_t         wnum;
        logic [8*160-1:0] rest;
        prog_words = 0;
        name = "none";
        fd = $fopen("verif/cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/cpu_cases.txt");
            abort_run();
        end else begin
            while ($fscanf(fd, "%s", kw) == 1) begin
                if (kw == "#") begin
                    code = $fgets(rest, fd);
                end else if (kw == "case") begin
                    code = $fscanf(fd, "%s", name);
                    check_fields(code, 1, kw);
                end else if (kw == "prog") begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    check_fields(code, 2, kw);
                    imem[addr[11:2]] = value;
                    prog_words++;
                end else if (kw == "trace") begin
                    code = $fscanf(fd, "%h %d %h", addr, wnum, value);
                    check_fields(code, 3, kw);
                    exp_name.push_back(name);
                    exp_pc.push_back(addr);
                    exp_wnum.push_back(wnum);
                    exp_wdata.push_back(value);
                end else begin
                    $display("Unknown line type %s in the case file", kw);
                    abort_run();
                end
            end
            $fclose(fd);
        end
        if (prog_words == 0 || exp_pc.size() == 0) begin
            $display("The case file holds no program or no expected trace");
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and SRAM models.

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        cycles          = 0;
        seen            = 0;
        drain           = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_cases();
        cycle_limit = 40 + 6 * prog_words;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

    // One-cycle read latency on both ports.
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        end
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[11:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    dmem[data_sram_addr[11:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Trace checking and end of run.

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d trace entries seen",
                     cycles, seen, exp_pc.size());
            abort_run();
        end else if (debug_wb_rf_we != 4'b0000) begin
            if (seen >= exp_pc.size()) begin
                $display("Register write at pc %h after the last expected trace entry",
                         debug_wb_pc);
                abort_run();
            end else begin
                check_we(exp_name[seen], 4'b1111, debug_wb_rf_we);
                check_pc(exp_name[seen], exp_pc[seen], debug_wb_pc);
                check_wnum(exp_name[seen], exp_wnum[seen], debug_wb_rf_wnum);
                check_wdata(exp_name[seen], exp_wdata[seen], debug_wb_rf_wdata);
                seen = seen + 1;
            end
        end else if (seen == exp_pc.size()) begin
            // A few idle cycles catch stray writes.
            drain = drain + 1;
            if (drain == 10) begin
                $display("All tests passed!");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/cpu_cases.txt
# prog <addr> <word> and trace <pc> <reg> <value>, addresses and values in hex, reg in decimal.
# A case line names the trace entries that follow it.
case alu
prog 1c000000 142468a1
prog 1c000004 0299e002
prog 1c000008 00150823
prog 1c00000c 02bffc04
prog 1c000010 00149065
prog 1c000014 00110c46
prog 1c000018 001208c7
prog 1c00001c 001018e8
trace 1c000000 1 12345000
trace 1c000004 2 00000678
trace 1c000008 3 12345678
trace 1c00000c 4 ffffffff
trace 1c000010 5 12345678
trace 1c000014 6 edcbb000
trace 1c000018 7 00000001
trace 1c00001c 8 edcbb001
case forward
prog 1c000020 02801409
prog 1c000024 02800529
prog 1c000028 02801c0a
prog 1c00002c 0010292b
trace 1c000020 9 00000005
trace 1c000024 9 00000006
trace 1c000028 10 00000007
trace 1c00002c 11 0000000d
case memory
prog 1c000030 0284000c
prog 1c000034 29800183
prog 1c000038 2880018d
prog 1c00003c 028005ae
prog 1c000040 29801188
prog 1c000044 2880118f
prog 1c000048 001039f0
trace 1c000030 12 00000100
trace 1c000038 13 12345678
trace 1c00003c 14 12345679
trace 1c000044 15 edcbb001
trace 1c000048 16 0000067a
case branch
prog 1c00004c 58000929
prog 1c000050 02844411
prog 1c000054 5c00092a
prog 1c000058 02888811
prog 1c00005c 5800092a
prog 1c000060 028ccc12
prog 1c000064 50000800
prog 1c000068 02911013
prog 1c00006c 5c000929
prog 1c000070 02955413
trace 1c000060 18 00000333
trace 1c000070 19 00000555
case zero_reg
prog 1c000074 029ffc00
prog 1c000078 00100414
prog 1c00007c 00150015
trace 1c000078 20 12345000
trace 1c00007c 21 00000000

//--- src.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/regfile.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mycpu_top.sv
verif/tb_mycpu.sv
